//--- verilog.f
verilog/regfile_pkg.sv
verilog/regfile_decode.sv
verilog/regfile_store.sv
verilog/regfile_job_ctrl.sv
verilog/regfile_resp.sv
verilog/hwpe_regfile_top.sv
dv/regfile_chk.sv
dv/tb_regfile.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert --timescale 1ns/1ps
TOP      := tb_regfile
FILELIST := verilog.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := all tests passed

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_regfile.sv
//------------------------------
// Register file testbench
//------------------------------
module tb_regfile;
  timeunit 1ns;
  timeprecision 100ps;

  import regfile_pkg::*;

  // Mirrors the DUT defaults
  localparam int unsigned N_CONTEXT      = 2;
  localparam int unsigned N_JOB_REGS     = 4;
  localparam int unsigned N_GENERIC_REGS = 2;
  localparam int unsigned CTX_W          = 1;
  localparam int unsigned ADDR_W         = REG_IDX_WIDTH + CTX_W;
  localparam int unsigned ENGINE_LATENCY = 5;
  localparam int unsigned MAX_CYCLES     = 2000;  // The tests take roughly 200 cycles

  logic                            clk_i;
  logic                            rst_ni;
  logic                            req_i;
  logic                            we_i;
  logic [ADDR_W-1:0]               addr_i;
  logic [31:0]                     wdata_i;
  logic [3:0]                      be_i;
  logic                            rvalid_o;
  logic [31:0]                     rdata_o;
  logic                            done_i;
  logic                            start_o;
  logic [CTX_W-1:0]                running_context_o;
  logic [N_JOB_REGS-1:0][31:0]     job_params_o;
  logic [N_GENERIC_REGS-1:0][31:0] generic_params_o;

  // Reference state of the register file
  logic [31:0] job_model [N_CONTEXT][N_JOB_REGS];
  logic [31:0] generic_model [N_GENERIC_REGS];
  logic        busy_model [N_CONTEXT];
  int unsigned pointer_model;
  int unsigned running_model;
  int unsigned offload_id_model;
  int unsigned running_id_model;
  int unsigned finished_model;

  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned cycle_count = 0;
  int unsigned start_count = 0;
  int unsigned done_count  = 0;
  int unsigned engine_wait = 0;
  logic        engine_run  = 1'b0;
  logic        engine_hold;

  hwpe_regfile_top i_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_i             (req_i),
    .we_i              (we_i),
    .addr_i            (addr_i),
    .wdata_i           (wdata_i),
    .be_i              (be_i),
    .rvalid_o          (rvalid_o),
    .rdata_o           (rdata_o),
    .done_i            (done_i),
    .start_o           (start_o),
    .running_context_o (running_context_o),
    .job_params_o      (job_params_o),
    .generic_params_o  (generic_params_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("tests failed");
    $finish;
  end

  // Engine answers each start with a done strobe unless held off
  initial begin
    done_i = 1'b0;
    forever begin
      @(negedge clk_i);
      done_i = 1'b0;
      if (start_o) begin
        start_count++;
        engine_run  = 1'b1;
        engine_wait = ENGINE_LATENCY;
      end else if (engine_run && !engine_hold) begin
        if (engine_wait > 1) begin
          engine_wait--;
        end else begin
          done_i     = 1'b1;
          engine_run = 1'b0;
          done_count++;
        end
      end
    end
  end

  function automatic logic [31:0] apply_byte_enables(input logic [31:0] old_word,
                                                     input logic [31:0] new_word,
                                                     input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic [31:0] expected_status();
    logic [31:0] word;
    word = '0;
    for (int c = 0; c < N_CONTEXT; c++) begin
      if (busy_model[c]) begin
        word[8*c +: 8] = 8'h01;
      end
    end
    return word;
  endfunction

  task automatic clear_models();
    for (int c = 0; c < N_CONTEXT; c++) begin
      busy_model[c] = 1'b0;
      for (int r = 0; r < N_JOB_REGS; r++) begin
        job_model[c][r] = '0;
      end
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      generic_model[g] = '0;
    end
    pointer_model    = 0;
    running_model    = 0;
    offload_id_model = 0;
    running_id_model = 0;
    finished_model   = 0;
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic bus_write(input int unsigned ctx, input int unsigned idx,
                           input logic [31:0] data, input logic [3:0] be);
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = ADDR_W'((ctx << REG_IDX_WIDTH) | idx);
    wdata_i = data;
    be_i    = be;
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic bus_read_check(input int unsigned ctx, input int unsigned idx,
                                input logic [31:0] exp, input string name);
    @(negedge clk_i);
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = ADDR_W'((ctx << REG_IDX_WIDTH) | idx);
    @(negedge clk_i);
    req_i = 1'b0;
    check_count++;
    assert (rvalid_o === 1'b1) else begin
      error_count++;
      $display("No read reply one cycle after the read of index %0d", idx);
    end
    check_word(name, exp, rdata_o);
  endtask

  task automatic read_finished();
    bus_read_check(0, IDX_FINISHED, finished_model, "rdata_o (finished)");
    finished_model = 0;  // Read clears
  endtask

  task automatic do_acquire();
    bus_read_check(0, IDX_ACQUIRE, offload_id_model, "rdata_o (acquire)");
    offload_id_model++;
  endtask

  task automatic do_trigger();
    bus_write(0, IDX_TRIGGER, 32'h0, 4'hF);
    busy_model[pointer_model] = 1'b1;
    pointer_model = (pointer_model + 1) % N_CONTEXT;
  endtask

  task automatic fill_context(input int unsigned ctx);
    logic [31:0] data;
    logic [3:0]  be;
    for (int r = 0; r < N_JOB_REGS; r++) begin
      data = $urandom();
      be   = 4'($urandom());
      bus_write(ctx, IDX_JOB_BASE + r, data, be);
      job_model[ctx][r] = apply_byte_enables(job_model[ctx][r], data, be);
    end
  endtask

  task automatic wait_for_done(input int unsigned target);
    int unsigned waited;
    waited = 0;
    while (done_count < target && waited < 100) begin
      @(posedge clk_i);  // Engine counts on the falling edge
      waited++;
    end
    assert (done_count >= target) else begin
      error_count++;
      $display("Engine done strobe never arrived after a start");
    end
    if (done_count >= target) begin
      busy_model[running_model] = 1'b0;
      running_model = (running_model + 1) % N_CONTEXT;
      if (finished_model < 2) begin
        finished_model++;
      end
      running_id_model++;
    end
    repeat (2) @(negedge clk_i);  // Running id settles two cycles after done
  endtask

  task automatic check_engine_params();
    check_word("running_context_o", 32'(running_model), 32'(running_context_o));
    for (int r = 0; r < N_JOB_REGS; r++) begin
      check_word($sformatf("job_params_o[%0d]", r), job_model[running_model][r],
                 job_params_o[r]);
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      check_word($sformatf("generic_params_o[%0d]", g), generic_model[g], generic_params_o[g]);
    end
  endtask

  task automatic test_reset_state();
    bus_read_check(0, IDX_STATUS, 32'h0, "rdata_o (status)");
    read_finished();
    bus_read_check(0, IDX_RUNNING_ID, 32'h0, "rdata_o (running id)");
    bus_read_check(0, 6, 32'hDEAD_BEEF, "rdata_o (index 6)");
    bus_read_check(0, 7, 32'hDEAD_BEEF, "rdata_o (index 7)");
    check_word("start_o pulse count", 0, start_count);
  endtask

  task automatic test_offload_flow();
    logic [31:0] data;
    logic [3:0]  be;
    do_acquire();
    fill_context(pointer_model);
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      data = $urandom();
      be   = 4'($urandom());
      bus_write(0, IDX_GENERIC_BASE + g, data, be);
      generic_model[g] = apply_byte_enables(generic_model[g], data, be);
    end
    for (int r = 0; r < N_JOB_REGS; r++) begin
      bus_read_check(pointer_model, IDX_JOB_BASE + r, job_model[pointer_model][r],
                     "rdata_o (job)");
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      bus_read_check(0, IDX_GENERIC_BASE + g, generic_model[g], "rdata_o (generic)");
    end
    do_trigger();
    check_word("start_o", 32'h1, 32'(start_o));  // One cycle after the trigger
    check_engine_params();
    wait_for_done(done_count + 1);
    bus_read_check(0, IDX_STATUS, expected_status(), "rdata_o (status)");
    read_finished();
    bus_read_check(0, IDX_RUNNING_ID, running_id_model, "rdata_o (running id)");
  endtask

  task automatic test_acquire_replies();
    engine_hold = 1'b1;
    for (int c = 0; c < N_CONTEXT; c++) begin
      do_acquire();
      if (c == 0) begin
        bus_read_check(0, IDX_ACQUIRE, 32'hFFFF_FFFE, "rdata_o (acquire, other offloading)");
      end
      fill_context(pointer_model);
      do_trigger();
    end
    bus_read_check(0, IDX_ACQUIRE, 32'hFFFF_FFFF, "rdata_o (acquire, all busy)");
    bus_read_check(0, IDX_STATUS, expected_status(), "rdata_o (status)");
  endtask

  task automatic test_context_rotation();
    int unsigned starts;
    check_engine_params();
    starts = start_count;
    engine_hold = 1'b0;
    wait_for_done(done_count + 1);
    check_word("start_o pulse count", starts + 1, start_count);  // Queued context starts
    check_engine_params();
    wait_for_done(done_count + 1);
    check_word("start_o pulse count", starts + 1, start_count);
    check_engine_params();
    bus_read_check(0, IDX_STATUS, 32'h0, "rdata_o (status)");
  endtask

  task automatic test_finished_and_clear();
    read_finished();
    for (int j = 0; j < 3; j++) begin
      do_acquire();
      do_trigger();
      wait_for_done(done_count + 1);
    end
    read_finished();
    read_finished();
    bus_read_check(0, IDX_RUNNING_ID, running_id_model, "rdata_o (running id)");
    bus_write(0, IDX_SOFT_CLEAR, 32'h0, 4'hF);
    clear_models();
    bus_read_check(0, IDX_STATUS, 32'h0, "rdata_o (status)");
    bus_read_check(0, IDX_RUNNING_ID, 32'h0, "rdata_o (running id)");
    read_finished();
    for (int c = 0; c < N_CONTEXT; c++) begin
      for (int r = 0; r < N_JOB_REGS; r++) begin
        bus_read_check(c, IDX_JOB_BASE + r, 32'h0, "rdata_o (job)");
      end
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      bus_read_check(0, IDX_GENERIC_BASE + g, 32'h0, "rdata_o (generic)");
    end
    check_engine_params();
    do_acquire();
  endtask

  initial begin
    void'($urandom(39));
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    be_i        = '0;
    engine_hold = 1'b0;
    clear_models();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset_state();
    test_offload_flow();
    test_acquire_replies();
    test_context_rotation();
    test_finished_and_clear();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- dv/regfile_chk.sv
//------------------------------
// Protocol assertions
//------------------------------
module regfile_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic we_i,
  input logic rvalid_o,
  input logic start_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Every read gets its reply in the next cycle, and only then
  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !we_i) |=> rvalid_o)
    else $error("read request got no reply in the next cycle");

  rvalid_only_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> $past(req_i && !we_i))
    else $error("read reply without a read request one cycle before");

  start_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_o |=> !start_o)
    else $error("start strobe held high for two cycles");

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> (!rvalid_o && !start_o))
    else $error("read reply or start strobe active during reset");

endmodule

bind hwpe_regfile_top regfile_chk i_chk (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .req_i    (req_i),
  .we_i     (we_i),
  .rvalid_o (rvalid_o),
  .start_o  (start_o)
);

//--- verilog/hwpe_regfile_top.sv
//------------------------------
// Accelerator register file
//------------------------------
module hwpe_regfile_top #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_JOB_REGS     = 4,
  parameter int unsigned N_GENERIC_REGS = 2,
  localparam int unsigned CTX_WIDTH  = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1,
  localparam int unsigned ADDR_WIDTH = regfile_pkg::REG_IDX_WIDTH + CTX_WIDTH
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [ADDR_WIDTH-1:0]                addr_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]   wdata_i,
  input  logic [regfile_pkg::DATA_WIDTH/8-1:0] be_i,
  output logic                                 rvalid_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0]   rdata_o,
  input  logic                                 done_i,
  output logic                                 start_o,
  output logic [CTX_WIDTH-1:0]                 running_context_o,
  output logic [N_JOB_REGS-1:0][regfile_pkg::DATA_WIDTH-1:0]     job_params_o,
  output logic [N_GENERIC_REGS-1:0][regfile_pkg::DATA_WIDTH-1:0] generic_params_o
);
  import regfile_pkg::*;

  logic [CTX_WIDTH-1:0]     ctx;
  logic [REG_IDX_WIDTH-1:0] idx;
  logic                     trigger;
  logic                     acquire;
  logic                     finished_read;
  logic                     soft_clear;
  logic                     job_we;
  logic                     generic_we;
  logic                     read;
  logic [SEL_WIDTH-1:0]     read_sel;
  logic                     store_clear;
  logic [DATA_WIDTH-1:0]    acquire_rdata;
  logic [DATA_WIDTH-1:0]    status_word;
  logic [DATA_WIDTH-1:0]    finished_word;
  logic [DATA_WIDTH-1:0]    running_id_word;
  logic [DATA_WIDTH-1:0]    job_rdata;
  logic [DATA_WIDTH-1:0]    generic_rdata;

  regfile_decode #(
    .N_CONTEXT      (N_CONTEXT),
    .N_JOB_REGS     (N_JOB_REGS),
    .N_GENERIC_REGS (N_GENERIC_REGS)
  ) i_decode (
    .req_i           (req_i),
    .we_i            (we_i),
    .addr_i          (addr_i),
    .ctx_o           (ctx),
    .idx_o           (idx),
    .trigger_o       (trigger),
    .acquire_o       (acquire),
    .finished_read_o (finished_read),
    .soft_clear_o    (soft_clear),
    .job_we_o        (job_we),
    .generic_we_o    (generic_we),
    .read_o          (read),
    .read_sel_o      (read_sel)
  );

  regfile_store #(
    .N_CONTEXT      (N_CONTEXT),
    .N_JOB_REGS     (N_JOB_REGS),
    .N_GENERIC_REGS (N_GENERIC_REGS)
  ) i_store (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clear_i           (store_clear),
    .job_we_i          (job_we),
    .generic_we_i      (generic_we),
    .ctx_i             (ctx),
    .idx_i             (idx),
    .wdata_i           (wdata_i),
    .be_i              (be_i),
    .running_context_i (running_context_o),
    .job_rdata_o       (job_rdata),
    .generic_rdata_o   (generic_rdata),
    .job_params_o      (job_params_o),
    .generic_params_o  (generic_params_o)
  );

  regfile_job_ctrl #(
    .N_CONTEXT (N_CONTEXT)
  ) i_job_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .trigger_i         (trigger),
    .acquire_i         (acquire),
    .finished_read_i   (finished_read),
    .soft_clear_i      (soft_clear),
    .done_i            (done_i),
    .acquire_rdata_o   (acquire_rdata),
    .status_o          (status_word),
    .finished_o        (finished_word),
    .running_id_o      (running_id_word),
    .running_context_o (running_context_o),
    .start_o           (start_o),
    .clear_o           (store_clear)
  );

  regfile_resp i_resp (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .read_i          (read),
    .read_sel_i      (read_sel),
    .idx_i           (idx),
    .acquire_rdata_i (acquire_rdata),
    .status_i        (status_word),
    .finished_i      (finished_word),
    .running_id_i    (running_id_word),
    .job_rdata_i     (job_rdata),
    .generic_rdata_i (generic_rdata),
    .rvalid_o        (rvalid_o),
    .rdata_o         (rdata_o)
  );

endmodule

//--- verilog/regfile_resp.sv
//------------------------------
// Read reply
//------------------------------
module regfile_resp (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  read_i,
  input  logic [regfile_pkg::SEL_WIDTH-1:0]     read_sel_i,
  input  logic [regfile_pkg::REG_IDX_WIDTH-1:0] idx_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]    acquire_rdata_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]    status_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]    finished_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]    running_id_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]    job_rdata_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]    generic_rdata_i,
  output logic                                  rvalid_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0]    rdata_o
);
  import regfile_pkg::*;

  logic [DATA_WIDTH-1:0] mandatory_word;
  logic [DATA_WIDTH-1:0] rdata_d;

  always_comb begin
    case (idx_i)
      IDX_FINISHED:   mandatory_word = finished_i;
      IDX_STATUS:     mandatory_word = status_i;
      IDX_RUNNING_ID: mandatory_word = running_id_i;
      default:        mandatory_word = '0;  // Soft clear reads zero
    endcase
  end

  always_comb begin
    case (read_sel_i)
      SEL_ACQUIRE:   rdata_d = acquire_rdata_i;
      SEL_MANDATORY: rdata_d = mandatory_word;
      SEL_JOB:       rdata_d = job_rdata_i;
      SEL_GENERIC:   rdata_d = generic_rdata_i;
      default:       rdata_d = RDATA_UNMAPPED;
    endcase
  end

  // Single stage, one reply per read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= read_i;
      if (read_i) begin
        rdata_o <= rdata_d;
      end
    end
  end

endmodule

//--- verilog/regfile_job_ctrl.sv
//------------------------------
// Job control
//------------------------------
module regfile_job_ctrl #(
  parameter int unsigned N_CONTEXT = 2,
  localparam int unsigned CTX_WIDTH = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               trigger_i,
  input  logic                               acquire_i,
  input  logic                               finished_read_i,
  input  logic                               soft_clear_i,
  input  logic                               done_i,
  output logic [regfile_pkg::DATA_WIDTH-1:0] acquire_rdata_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0] status_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0] finished_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0] running_id_o,
  output logic [CTX_WIDTH-1:0]               running_context_o,
  output logic                               start_o,
  output logic                               clear_o
);
  import regfile_pkg::*;

  localparam int unsigned FIN_WIDTH = $clog2(FINISHED_MAX + 1);

  logic [CTX_WIDTH-1:0]    pointer_q;   // Next context to fill
  logic [CTX_WIDTH-1:0]    running_q;   // Context the engine works on
  logic [CTX_WIDTH-1:0]    running_next;
  logic [N_CONTEXT-1:0]    busy_q;
  logic [MAX_CONTEXT-1:0]  busy_pad;
  logic                    critical_q;
  logic                    engine_busy_q;
  logic [JOB_ID_WIDTH-1:0] offload_id_q;
  logic [JOB_ID_WIDTH-1:0] running_id_q;
  logic                    running_id_incr_q;
  logic [FIN_WIDTH-1:0]    finished_q;
  logic                    start_q;
  logic                    acquire_ok;
  logic                    trigger_ok;
  logic                    job_done;
  logic                    next_busy;
  logic                    start_d;

  function automatic logic [CTX_WIDTH-1:0] next_ctx(input logic [CTX_WIDTH-1:0] ctx);
    if (ctx == CTX_WIDTH'(N_CONTEXT - 1)) begin
      return '0;
    end
    return ctx + 1'b1;
  endfunction

  assign acquire_ok   = acquire_i && !critical_q && !(&busy_q);
  assign trigger_ok   = trigger_i && !busy_q[pointer_q];
  assign job_done     = done_i && engine_busy_q;
  assign running_next = next_ctx(running_q);

  // Following context already queued, or being queued right now
  assign next_busy = (running_next != running_q) &&
                     (busy_q[running_next] || (trigger_ok && pointer_q == running_next));
  assign start_d   = (trigger_ok && !engine_busy_q) || (job_done && next_busy);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pointer_q         <= '0;
      running_q         <= '0;
      busy_q            <= '0;
      critical_q        <= 1'b0;
      engine_busy_q     <= 1'b0;
      offload_id_q      <= '0;
      running_id_q      <= '0;
      running_id_incr_q <= 1'b0;
      finished_q        <= '0;
      start_q           <= 1'b0;
    end else if (soft_clear_i) begin
      pointer_q         <= '0;
      running_q         <= '0;
      busy_q            <= '0;
      critical_q        <= 1'b0;
      engine_busy_q     <= 1'b0;
      offload_id_q      <= '0;
      running_id_q      <= '0;
      running_id_incr_q <= 1'b0;
      finished_q        <= '0;
      start_q           <= 1'b0;
    end else begin
      if (trigger_ok) begin
        busy_q[pointer_q] <= 1'b1;
        pointer_q         <= next_ctx(pointer_q);
      end
      if (job_done) begin
        busy_q[running_q] <= 1'b0;  // Never the trigger target while running
        running_q         <= running_next;
      end
      if (acquire_ok) begin
        critical_q   <= 1'b1;
        offload_id_q <= offload_id_q + 1'b1;
      end else if (trigger_i) begin
        critical_q <= 1'b0;
      end
      running_id_incr_q <= job_done;  // Id moves one cycle behind done
      if (running_id_incr_q) begin
        running_id_q <= running_id_q + 1'b1;
      end
      if (finished_read_i) begin
        finished_q <= '0;
      end else if (job_done && finished_q < FINISHED_MAX) begin
        finished_q <= finished_q + 1'b1;
      end
      start_q <= start_d;
      if (start_d) begin
        engine_busy_q <= 1'b1;
      end else if (job_done) begin
        engine_busy_q <= 1'b0;
      end
    end
  end

  always_comb begin
    if (critical_q) begin
      acquire_rdata_o = RESP_OTHER_OFFLOADING;
    end else if (&busy_q) begin
      acquire_rdata_o = RESP_ALL_BUSY;
    end else begin
      acquire_rdata_o = DATA_WIDTH'(offload_id_q);
    end
  end

  // One status byte per context, unused bytes read zero
  assign busy_pad = MAX_CONTEXT'(busy_q);
  always_comb begin
    status_o = '0;
    for (int c = 0; c < MAX_CONTEXT; c++) begin
      if (busy_pad[c]) begin
        status_o[8*c +: 8] = STATUS_BUSY;
      end
    end
  end

  assign finished_o        = DATA_WIDTH'(finished_q);
  assign running_id_o      = DATA_WIDTH'(running_id_q);
  assign running_context_o = running_q;
  assign start_o           = start_q;
  assign clear_o           = soft_clear_i;  // Store clears on the same edge

endmodule

//--- verilog/regfile_store.sv
//------------------------------
// Parameter storage
//------------------------------
module regfile_store #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_JOB_REGS     = 4,
  parameter int unsigned N_GENERIC_REGS = 2,
  localparam int unsigned CTX_WIDTH = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    job_we_i,
  input  logic                                    generic_we_i,
  input  logic [CTX_WIDTH-1:0]                    ctx_i,
  input  logic [regfile_pkg::REG_IDX_WIDTH-1:0]   idx_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]      wdata_i,
  input  logic [regfile_pkg::DATA_WIDTH/8-1:0]    be_i,
  input  logic [CTX_WIDTH-1:0]                    running_context_i,
  output logic [regfile_pkg::DATA_WIDTH-1:0]      job_rdata_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0]      generic_rdata_o,
  output logic [N_JOB_REGS-1:0][regfile_pkg::DATA_WIDTH-1:0]     job_params_o,
  output logic [N_GENERIC_REGS-1:0][regfile_pkg::DATA_WIDTH-1:0] generic_params_o
);
  import regfile_pkg::*;

  localparam int unsigned N_BYTES = DATA_WIDTH / 8;

  logic [N_CONTEXT-1:0][N_JOB_REGS-1:0][DATA_WIDTH-1:0] job_q;
  logic [N_GENERIC_REGS-1:0][DATA_WIDTH-1:0]            generic_q;

  function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_w,
                                                         input logic [DATA_WIDTH-1:0] new_w,
                                                         input logic [N_BYTES-1:0]    be);
    logic [DATA_WIDTH-1:0] res;
    res = old_w;
    for (int b = 0; b < N_BYTES; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      job_q     <= '0;
      generic_q <= '0;
    end else if (clear_i) begin
      job_q     <= '0;
      generic_q <= '0;
    end else begin
      for (int c = 0; c < N_CONTEXT; c++) begin
        for (int r = 0; r < N_JOB_REGS; r++) begin
          if (job_we_i && ctx_i == c && idx_i == IDX_JOB_BASE + r) begin
            job_q[c][r] <= merge_bytes(job_q[c][r], wdata_i, be_i);
          end
        end
      end
      for (int g = 0; g < N_GENERIC_REGS; g++) begin
        if (generic_we_i && idx_i == IDX_GENERIC_BASE + g) begin
          generic_q[g] <= merge_bytes(generic_q[g], wdata_i, be_i);
        end
      end
    end
  end

  // Read port, registered later in the reply stage
  always_comb begin
    job_rdata_o     = '0;
    generic_rdata_o = '0;
    for (int c = 0; c < N_CONTEXT; c++) begin
      for (int r = 0; r < N_JOB_REGS; r++) begin
        if (ctx_i == c && idx_i == IDX_JOB_BASE + r) begin
          job_rdata_o = job_q[c][r];
        end
      end
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      if (idx_i == IDX_GENERIC_BASE + g) begin
        generic_rdata_o = generic_q[g];
      end
    end
  end

  assign job_params_o     = job_q[running_context_i];  // Engine sees its own context
  assign generic_params_o = generic_q;

endmodule

//--- verilog/regfile_decode.sv
//------------------------------
// Bus access decode
//------------------------------
module regfile_decode #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_JOB_REGS     = 4,
  parameter int unsigned N_GENERIC_REGS = 2,
  localparam int unsigned CTX_WIDTH  = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1,
  localparam int unsigned ADDR_WIDTH = regfile_pkg::REG_IDX_WIDTH + CTX_WIDTH
) (
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [ADDR_WIDTH-1:0]                 addr_i,
  output logic [CTX_WIDTH-1:0]                  ctx_o,
  output logic [regfile_pkg::REG_IDX_WIDTH-1:0] idx_o,
  output logic                                  trigger_o,
  output logic                                  acquire_o,
  output logic                                  finished_read_o,
  output logic                                  soft_clear_o,
  output logic                                  job_we_o,
  output logic                                  generic_we_o,
  output logic                                  read_o,
  output logic [regfile_pkg::SEL_WIDTH-1:0]     read_sel_o
);
  import regfile_pkg::*;

  logic is_job;
  logic is_generic;
  logic is_mandatory;
  logic rd;
  logic wr;

  assign ctx_o = addr_i[ADDR_WIDTH-1:REG_IDX_WIDTH];
  assign idx_o = addr_i[REG_IDX_WIDTH-1:0];

  assign rd = req_i && !we_i;
  assign wr = req_i && we_i;

  // Slots past the configured counts fall through to unmapped
  assign is_job = (idx_o >= IDX_JOB_BASE) && (idx_o < IDX_JOB_BASE + N_JOB_REGS) &&
                  (ctx_o < N_CONTEXT);
  assign is_generic = (idx_o >= IDX_GENERIC_BASE) &&
                      (idx_o < IDX_GENERIC_BASE + N_GENERIC_REGS);
  assign is_mandatory = (idx_o >= IDX_FINISHED) && (idx_o <= IDX_SOFT_CLEAR);

  assign trigger_o       = wr && (idx_o == IDX_TRIGGER);
  assign acquire_o       = rd && (idx_o == IDX_ACQUIRE);  // A read is the acquire
  assign finished_read_o = rd && (idx_o == IDX_FINISHED);
  assign soft_clear_o    = wr && (idx_o == IDX_SOFT_CLEAR);
  assign job_we_o        = wr && is_job;
  assign generic_we_o    = wr && is_generic;
  assign read_o          = rd;

  always_comb begin
    if (idx_o == IDX_ACQUIRE) begin
      read_sel_o = SEL_ACQUIRE;
    end else if (is_mandatory) begin
      read_sel_o = SEL_MANDATORY;
    end else if (is_job) begin
      read_sel_o = SEL_JOB;
    end else if (is_generic) begin
      read_sel_o = SEL_GENERIC;
    end else begin
      read_sel_o = SEL_UNMAPPED;  // Trigger slot and holes
    end
  end

endmodule

//--- verilog/regfile_pkg.sv
//------------------------------
// Register file definitions
//------------------------------
package regfile_pkg;

  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned REG_IDX_WIDTH = 5;  // 32 slots per context
  localparam int unsigned MAX_CONTEXT   = 4;  // One status byte each
  localparam int unsigned JOB_ID_WIDTH  = 8;
  localparam int unsigned FINISHED_MAX  = 2;

  // Mandatory registers
  localparam int unsigned IDX_TRIGGER    = 0;
  localparam int unsigned IDX_ACQUIRE    = 1;
  localparam int unsigned IDX_FINISHED   = 2;  // Cleared on read
  localparam int unsigned IDX_STATUS     = 3;
  localparam int unsigned IDX_RUNNING_ID = 4;
  localparam int unsigned IDX_SOFT_CLEAR = 5;

  localparam int unsigned IDX_GENERIC_BASE = 8;
  localparam int unsigned IDX_JOB_BASE     = 16;  // Contexted from here up

  // Fixed reply words
  localparam logic [DATA_WIDTH-1:0] RESP_OTHER_OFFLOADING = 32'hFFFF_FFFE;  // -2
  localparam logic [DATA_WIDTH-1:0] RESP_ALL_BUSY         = 32'hFFFF_FFFF;  // -1
  localparam logic [DATA_WIDTH-1:0] RDATA_UNMAPPED        = 32'hDEAD_BEEF;

  localparam logic [7:0] STATUS_BUSY = 8'h01;

  // Source of the read reply, chosen at decode time
  localparam int unsigned SEL_WIDTH = 3;
  localparam logic [SEL_WIDTH-1:0] SEL_UNMAPPED  = 3'd0;
  localparam logic [SEL_WIDTH-1:0] SEL_ACQUIRE   = 3'd1;
  localparam logic [SEL_WIDTH-1:0] SEL_MANDATORY = 3'd2;
  localparam logic [SEL_WIDTH-1:0] SEL_JOB       = 3'd3;
  localparam logic [SEL_WIDTH-1:0] SEL_GENERIC   = 3'd4;

endpackage
